// ==== rtl/spi_pkg.sv ====
package spi_pkg;

  // Command tag width, echoed back in the response
  localparam int TAG_W = 4;

  // Number of slave selects on the bus
  localparam int NUM_CS = 2;

  // Select field width, enough to index NUM_CS
  localparam int CS_W = 1;

  // Command header that rides along with the transfer
  typedef struct packed {
    logic [TAG_W-1:0] tag;     // Host tag, returned unchanged
    logic [CS_W-1:0]  cs_sel;  // Which ss_n to pull low
  } spi_hdr_t;

  // Response header seen by the host
  // Received word travels next to it as rsp_data
  typedef struct packed {
    logic [TAG_W-1:0] tag;     // Tag of the finished command
    logic [CS_W-1:0]  cs_sel;  // Slave that answered
  } spi_rsp_t;

endpackage

// ==== rtl/spi_cmd_stage.sv ====
`timescale 1ns/1ns

module spi_cmd_stage
  import spi_pkg::*;
#(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,   // One-cycle command strobe
  input  spi_hdr_t              cmd_hdr,
  input  logic [DATA_WIDTH-1:0] cmd_data,
  input  logic                  idle,        // Master ready for a start
  output logic                  start,       // One-cycle launch pulse
  output spi_hdr_t              start_hdr,
  output logic [DATA_WIDTH-1:0] start_data,
  output logic                  busy,
  output logic                  overflow     // Command dropped
);

  logic                  full;        // Buffer holds a command
  spi_hdr_t              buf_hdr;     // Buffered header
  logic [DATA_WIDTH-1:0] buf_data;    // Buffered transmit word
  logic                  can_launch;  // Master free, no launch in flight
  logic                  launch_buf;  // Buffer entry goes out
  logic                  launch_cmd;  // New command bypasses buffer
  logic                  store_cmd;   // New command parks in buffer

  // start still high means the master has not dropped idle yet
  assign can_launch = idle && !start;
  assign launch_buf = full && can_launch;
  assign launch_cmd = cmd_valid && !full && can_launch;
  assign store_cmd  = cmd_valid && !full && !can_launch;

  assign busy = full || start || !idle;  // Anything queued or running

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start    <= 1'b0;
      full     <= 1'b0;
      overflow <= 1'b0;
    end else begin
      start    <= launch_buf || launch_cmd;
      overflow <= cmd_valid && full;  // Full buffer, command lost
      if (launch_buf) begin
        full <= 1'b0;
      end else if (store_cmd) begin
        full <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (launch_buf) begin
      start_hdr  <= buf_hdr;   // Oldest command first
      start_data <= buf_data;
    end else if (launch_cmd) begin
      start_hdr  <= cmd_hdr;
      start_data <= cmd_data;
    end
    if (store_cmd) begin
      buf_hdr  <= cmd_hdr;
      buf_data <= cmd_data;
    end
  end

endmodule

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ns

module spi_master
  import spi_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int CLK_DIV    = 4   // Clocks per sclk half-period, at least 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,       // Launch pulse, only while idle
  input  spi_hdr_t              start_hdr,
  input  logic [DATA_WIDTH-1:0] start_data,
  input  logic                  miso,
  output logic                  idle,
  output logic                  done,        // One-cycle completion pulse
  output spi_hdr_t              done_hdr,
  output logic [DATA_WIDTH-1:0] rx_word,
  output logic                  sclk,
  output logic                  mosi,
  output logic [NUM_CS-1:0]     ss_n
);

  localparam int CNT_W = $clog2(CLK_DIV);
  localparam int BIT_W = $clog2(DATA_WIDTH);
  localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(CLK_DIV - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_WIDTH - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,   // ss_n low, MSB on mosi, sclk low
    ST_SHIFT,   // DATA_WIDTH sclk periods
    ST_HOLD     // sclk low before ss_n rises
  } state_t;

  state_t                state;
  logic [CNT_W-1:0]      half_cnt;   // Clocks within a half-period
  logic [BIT_W-1:0]      bit_cnt;    // Bits sampled so far minus one
  logic                  half_end;   // Last clock of a half-period
  logic [DATA_WIDTH-1:0] tx_sr;      // Transmit shift, MSB on mosi
  logic [DATA_WIDTH-1:0] rx_sr;      // Receive shift, fills from LSB
  spi_hdr_t              hdr_q;      // Header latched at start

  assign half_end = (half_cnt == CNT_MAX);
  assign idle     = (state == ST_IDLE) && !done;  // Rises the cycle after done
  assign mosi     = tx_sr[DATA_WIDTH-1];
  assign rx_word  = rx_sr;
  assign done_hdr = hdr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      ss_n     <= '1;     // All slaves deselected
      done     <= 1'b0;
      tx_sr    <= '0;     // Keeps mosi low out of reset
    end else begin
      done <= 1'b0;
      if (state != ST_IDLE) begin
        half_cnt <= half_end ? '0 : half_cnt + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (start) begin
            state    <= ST_SETUP;
            half_cnt <= '0;
            bit_cnt  <= '0;
            tx_sr    <= start_data;                   // MSB out right away
            ss_n     <= ~(NUM_CS'(1) << start_hdr.cs_sel);
          end
        end
        ST_SETUP: begin
          if (half_end) begin
            state <= ST_SHIFT;
            sclk  <= 1'b1;                            // First rising edge
          end
        end
        ST_SHIFT: begin
          if (half_end) begin
            if (sclk) begin
              sclk  <= 1'b0;
              tx_sr <= {tx_sr[DATA_WIDTH-2:0], 1'b0}; // Next bit on falling edge
            end else if (bit_cnt == LAST_BIT) begin
              state <= ST_HOLD;                       // Last period finished
            end else begin
              sclk    <= 1'b1;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_HOLD: begin
          if (half_end) begin
            state <= ST_IDLE;
            ss_n  <= '1;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload capture, miso taken as sclk goes high
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      hdr_q <= start_hdr;
    end
    if (half_end && (state == ST_SETUP || (state == ST_SHIFT && !sclk &&
        bit_cnt != LAST_BIT))) begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], miso};
    end
  end

endmodule

// ==== rtl/spi_rsp_stage.sv ====
`timescale 1ns/1ns

module spi_rsp_stage
  import spi_pkg::*;
#(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  done,       // Transfer finished
  input  spi_hdr_t              done_hdr,
  input  logic [DATA_WIDTH-1:0] rx_word,
  output logic                  rsp_valid,  // One cycle after done
  output spi_rsp_t              rsp,
  output logic [DATA_WIDTH-1:0] rsp_data
);

  spi_rsp_t rsp_next;  // Header mapped to the response layout

  always_comb begin
    rsp_next.tag    = done_hdr.tag;
    rsp_next.cs_sel = done_hdr.cs_sel;
  end

  // Strobe only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= done;
    end
  end

  // Held until the next done, a polling host can read it late
  always_ff @(posedge clk) begin
    if (done) begin
      rsp      <= rsp_next;
      rsp_data <= rx_word;
    end
  end

endmodule

// ==== rtl/spi_bridge_top.sv ====
`timescale 1ns/1ns

module spi_bridge_top
  import spi_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int CLK_DIV    = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  spi_hdr_t              cmd_hdr,
  input  logic [DATA_WIDTH-1:0] cmd_data,
  input  logic                  miso,
  output logic                  busy,
  output logic                  overflow,
  output logic                  rsp_valid,
  output spi_rsp_t              rsp,
  output logic [DATA_WIDTH-1:0] rsp_data,
  output logic                  sclk,
  output logic                  mosi,
  output logic [NUM_CS-1:0]     ss_n
);

  logic                  start;       // Command stage to master
  spi_hdr_t              start_hdr;
  logic [DATA_WIDTH-1:0] start_data;
  logic                  idle;        // Master back to command stage
  logic                  done;        // Master to response stage
  spi_hdr_t              done_hdr;
  logic [DATA_WIDTH-1:0] rx_word;

  spi_cmd_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) cmd_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_hdr    (cmd_hdr),
    .cmd_data   (cmd_data),
    .idle       (idle),
    .start      (start),
    .start_hdr  (start_hdr),
    .start_data (start_data),
    .busy       (busy),
    .overflow   (overflow)
  );

  spi_master #(
    .DATA_WIDTH (DATA_WIDTH),
    .CLK_DIV    (CLK_DIV)
  ) master_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .start_hdr  (start_hdr),
    .start_data (start_data),
    .miso       (miso),
    .idle       (idle),
    .done       (done),
    .done_hdr   (done_hdr),
    .rx_word    (rx_word),
    .sclk       (sclk),
    .mosi       (mosi),
    .ss_n       (ss_n)
  );

  spi_rsp_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) rsp_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .done       (done),
    .done_hdr   (done_hdr),
    .rx_word    (rx_word),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_data   (rsp_data)
  );

endmodule

// ==== test/spi_slave_model.sv ====
`timescale 1ns/1ns

module spi_slave_model #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  cs_n,      // Low while any select is active
  input  logic                  sclk,
  input  logic                  mosi,
  output logic                  miso,
  input  logic [DATA_WIDTH-1:0] reply,     // Taken as the frame opens
  output logic [DATA_WIDTH-1:0] captured   // Updated when cs_n rises
);

  logic [DATA_WIDTH-1:0] tx_sr;  // Top bit drives miso
  logic [DATA_WIDTH-1:0] rx_sr;  // First mosi bit ends up on top

  assign miso = tx_sr[DATA_WIDTH-1];

  // One pass per frame, mode 0 so sample on rise and shift on fall
  initial begin
    tx_sr    = '0;
    rx_sr    = '0;
    captured = '0;
    forever begin
      @(negedge cs_n);
      tx_sr = reply;  // MSB out before the first rising edge
      rx_sr = '0;
      while (!cs_n) begin
        @(posedge sclk or posedge cs_n);
        if (!cs_n) begin
          rx_sr = {rx_sr[DATA_WIDTH-2:0], mosi};  // mosi settled since last fall
          @(negedge sclk or posedge cs_n);
          if (!cs_n) begin
            tx_sr = {tx_sr[DATA_WIDTH-2:0], 1'b0};  // Next reply bit
          end
        end
      end
      captured = rx_sr;
    end
  end

endmodule

// ==== test/tb_spi_bridge.sv ====
`timescale 1ns/1ns

module tb_spi_bridge
  import spi_pkg::*;
();

  localparam int DATA_WIDTH = 8;
  localparam int CLK_DIV    = 4;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [CS_W-1:0]       cs_sel;
    logic [DATA_WIDTH-1:0] tx;     // Word the master sends
    logic [DATA_WIDTH-1:0] reply;  // Word the slave answers with
    logic                  drop;   // Expected to be discarded
  } golden_t;

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_valid;
  spi_hdr_t              cmd_hdr;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  busy;
  logic                  overflow;
  logic                  rsp_valid;
  spi_rsp_t              rsp;
  logic [DATA_WIDTH-1:0] rsp_data;
  logic                  sclk;
  logic                  mosi;
  logic                  miso;
  logic [NUM_CS-1:0]     ss_n;
  logic [DATA_WIDTH-1:0] slave_reply = '0;  // Answer for the oldest open command
  logic [DATA_WIDTH-1:0] slave_captured;    // Last word seen on mosi

  golden_t     lines_q[$];       // Whole golden file
  golden_t     exp_q[$];         // Accepted commands in issue order
  int          rsp_idx = 0;      // Responses seen so far
  logic        last_drop;        // Previous cycle sent a drop line
  logic        lines_ready;

  spi_bridge_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .CLK_DIV    (CLK_DIV)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_hdr   (cmd_hdr),
    .cmd_data  (cmd_data),
    .miso      (miso),
    .busy      (busy),
    .overflow  (overflow),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_data  (rsp_data),
    .sclk      (sclk),
    .mosi      (mosi),
    .ss_n      (ss_n)
  );

  spi_slave_model #(
    .DATA_WIDTH (DATA_WIDTH)
  ) slave_i (
    .cs_n     (&ss_n),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .reply    (slave_reply),
    .captured (slave_captured)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_plain(input string why);
    $display("ERROR: %s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // Only the chosen select low and all others high
  function automatic logic [NUM_CS-1:0] select_pattern(input logic [CS_W-1:0] cs);
    logic [NUM_CS-1:0] pat;
    pat     = '1;
    pat[cs] = 1'b0;
    return pat;
  endfunction

  function automatic int outstanding();
    return exp_q.size() - rsp_idx;  // Accepted but not yet answered
  endfunction

  task automatic read_golden();
    int          fd;
    int          n;
    string       text;
    logic [31:0] f_tag, f_cs, f_tx, f_rx, f_drop;
    golden_t     g;
    fd = $fopen("test/spi_golden.txt", "r");
    if (fd == 0) begin
      fail_plain("cannot open test/spi_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(text, fd);
        if (n > 0 && text.getc(0) != "#") begin  // Skip column notes
          if ($sscanf(text, "%h %h %h %h %h", f_tag, f_cs, f_tx, f_rx, f_drop) == 5) begin
            g.tag    = f_tag[TAG_W-1:0];
            g.cs_sel = f_cs[CS_W-1:0];
            g.tx     = f_tx[DATA_WIDTH-1:0];
            g.reply  = f_rx[DATA_WIDTH-1:0];
            g.drop   = f_drop[0];
            lines_q.push_back(g);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One clock with inputs 10 ns after the edge and overflow checked mid-cycle
  task automatic drive_cycle(input logic valid, input golden_t g);
    @(posedge clk);
    #10;
    cmd_valid      = valid;
    cmd_hdr.tag    = g.tag;
    cmd_hdr.cs_sel = g.cs_sel;
    cmd_data       = g.tx;
    if (valid && !g.drop) begin
      exp_q.push_back(g);
    end
    @(negedge clk);
    check_eq("overflow", 32'(overflow), 32'(last_drop));  // Reflects last cycle's command
    last_drop = valid && g.drop;
    #10;  // Lets the response monitor finish first
  endtask

  initial begin
    golden_t g;
    int      gap;
    void'($urandom(32'h3390));
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_hdr     = '0;
    cmd_data    = '0;
    last_drop   = 1'b0;
    lines_ready = 1'b0;
    read_golden();
    if (lines_q.size() == 0) begin
      fail_plain("golden file holds no command lines");
    end else begin
      lines_ready = 1'b1;
      repeat (3) @(posedge clk);
      #10;
      rst_n = 1'b1;
      @(negedge clk);
      check_eq("ss_n", 32'(ss_n), 32'((1 << NUM_CS) - 1));
      check_eq("sclk", 32'(sclk), 32'(0));
      check_eq("mosi", 32'(mosi), 32'(0));
      check_eq("rsp_valid", 32'(rsp_valid), 32'(0));
      check_eq("busy", 32'(busy), 32'(0));
      check_eq("overflow", 32'(overflow), 32'(0));
      for (int i = 0; i < lines_q.size(); i++) begin
        g = lines_q[i];
        if (!g.drop) begin
          while (outstanding() >= 2) begin  // Master and buffer both taken
            drive_cycle(1'b0, '0);
          end
          gap = (i == 1) ? 0 : $urandom_range(3, 0);  // Second command right behind the first
          repeat (gap) drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b1, g);  // Drop lines go right behind the previous one
      end
      drive_cycle(1'b0, '0);
      while (outstanding() > 0) begin
        drive_cycle(1'b0, '0);
      end
      check_eq("busy", 32'(busy), 32'(0));
      repeat (4) drive_cycle(1'b0, '0);  // No stray responses
      $display("All tests passed");
      $finish;
    end
  end

  // Response checker that also hands the slave its next answer
  always @(negedge clk) begin
    if (rst_n && rsp_valid) begin
      if (rsp_idx >= exp_q.size()) begin
        fail_plain("response strobe with no accepted command left");
      end else begin
        check_eq("rsp.tag", 32'(rsp.tag), 32'(exp_q[rsp_idx].tag));
        check_eq("rsp.cs_sel", 32'(rsp.cs_sel), 32'(exp_q[rsp_idx].cs_sel));
        check_eq("rsp_data", 32'(rsp_data), 32'(exp_q[rsp_idx].reply));
        check_eq("slave_captured", 32'(slave_captured), 32'(exp_q[rsp_idx].tx));
        rsp_idx = rsp_idx + 1;
        if (outstanding() > (cmd_valid ? 1 : 0)) begin  // Buffered entry still queued
          check_eq("busy", 32'(busy), 32'(1));
        end
      end
    end
    slave_reply = (rsp_idx < exp_q.size()) ? exp_q[rsp_idx].reply : '0;
  end

  // Select check on every sclk rise
  always @(posedge sclk) begin
    if (outstanding() == 0) begin
      fail_plain("sclk pulsed with no command outstanding");
    end else begin
      check_eq("ss_n", 32'(ss_n), 32'(select_pattern(exp_q[rsp_idx].cs_sel)));
    end
  end

  initial begin
    int limit;
    wait (lines_ready);
    limit = lines_q.size() * 100 + 200;  // Roughly 75 cycles per transfer plus gaps
    repeat (limit) @(posedge clk);
    fail_plain($sformatf("run timed out after %0d cycles", limit));
  end

endmodule

// ==== test/spi_golden.txt ====
# tag cs_sel tx_word reply_word drop, all hex
# drop=1 lines follow two accepted commands and must be discarded
1 0 a5 3c 0
2 1 5a c3 0
3 0 ff 00 1
4 1 00 ff 0
5 0 81 7e 0
6 1 12 34 0
7 0 de ad 1
8 1 be ef 0
9 0 01 80 0
a 1 f0 0f 1
b 0 69 96 0
c 1 55 aa 0

// ==== filelist.f ====
rtl/spi_pkg.sv
rtl/spi_cmd_stage.sv
rtl/spi_master.sv
rtl/spi_rsp_stage.sv
rtl/spi_bridge_top.sv
test/spi_slave_model.sv
test/tb_spi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build the SPI bridge testbench with Verilator and run it from the project root
verilator --binary --timing --timescale 1ns/1ns --top-module tb_spi_bridge \
  -f filelist.f -o sim_tb \
  && ./obj_dir/sim_tb \
  || exit 1
